/* build.f */
source/uart_regs_pkg.sv
source/axil_write_channel.sv
source/axil_read_channel.sv
source/uart_reg_map.sv
source/uart_data_path.sv
source/uart_regs_top.sv
test/tb_uart_regs.sv

/* test/tb_uart_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_uart_regs;

    localparam int TIMEOUT = 50;

    logic        clk;
    logic        rst;
    logic        i_s_axil_awvalid;
    logic [7:0]  i_s_axil_awaddr;
    logic        o_s_axil_awready;
    logic        i_s_axil_wvalid;
    logic [31:0] i_s_axil_wdata;
    logic        o_s_axil_wready;
    logic        o_s_axil_bvalid;
    logic [1:0]  o_s_axil_bresp;
    logic        i_s_axil_bready;
    logic        i_s_axil_arvalid;
    logic [7:0]  i_s_axil_araddr;
    logic        o_s_axil_arready;
    logic        o_s_axil_rvalid;
    logic [31:0] o_s_axil_rdata;
    logic [1:0]  o_s_axil_rresp;
    logic        i_s_axil_rready;
    logic [31:0] o_cr1;
    logic [31:0] o_cr2;
    logic [31:0] o_brr;
    logic [7:0]  o_tx_data;
    logic        o_tx_valid;
    logic        i_tx_ready;
    logic [7:0]  i_rx_data;
    logic        i_rx_valid;
    logic        o_rx_ready;
    logic        i_pe;
    logic        i_fe;
    logic        i_ore;
    logic        i_idle;
    logic        i_tc;
    logic        i_busy;
    logic        i_txfe;

    // shadow register file indexed by offset / 4
    logic [31:0] shadow [0:7];
    logic [31:0] sticky;
    logic        tx_pending;
    logic        rx_full;
    logic [31:0] lfsr;
    logic [7:0]  rd_addr_seen;
    logic [31:0] rd_got;
    logic [31:0] rd_exp;
    event        read_done;

    uart_regs_top uart_regs_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ====================
    // helpers
    // ====================
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] bits;
        int          k;
        bits = '0;
        for (k = 0; k < n; k++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        next_bits = bits;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("ERROR: timed out at %0t waiting for the %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // reference model of every readable offset
    function automatic logic [31:0] expected_read(input logic [7:0] addr);
        logic [31:0] isr;
        isr = sticky;
        isr[uart_regs_pkg::ISR_RXNE] = rx_full;
        isr[uart_regs_pkg::ISR_TXE]  = !tx_pending;
        isr[uart_regs_pkg::ISR_BUSY] = i_busy;
        isr[uart_regs_pkg::ISR_TXFE] = i_txfe;
        case (addr)
            uart_regs_pkg::OFF_CR1, uart_regs_pkg::OFF_CR2, uart_regs_pkg::OFF_BRR,
            uart_regs_pkg::OFF_RDR, uart_regs_pkg::OFF_TDR: expected_read = shadow[addr[4:2]];
            uart_regs_pkg::OFF_ISR: expected_read = isr;
            // icr and holes
            default: expected_read = '0;
        endcase
    endfunction

    // ====================
    // axi-lite master
    // ====================
    // order 1 sends AW first and order 2 sends W first
    // any other order sends both together
    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             input logic [1:0] order);
        logic aw_done;
        logic w_done;
        int   t;
        aw_done = 1'b0;
        w_done  = 1'b0;
        t = 0;
        while (!(aw_done && w_done)) begin
            @(posedge clk);
            i_s_axil_awvalid <= !aw_done && (order != 2'd2 || w_done);
            i_s_axil_awaddr  <= addr;
            i_s_axil_wvalid  <= !w_done && (order != 2'd1 || aw_done);
            i_s_axil_wdata   <= data;
            @(negedge clk);
            aw_done = aw_done || (i_s_axil_awvalid && o_s_axil_awready);
            w_done  = w_done || (i_s_axil_wvalid && o_s_axil_wready);
            t++;
            if (t > TIMEOUT) fail_timeout("write address or data handshake");
        end
        check(o_s_axil_bvalid, 1, "bvalid with the last write handshake");
        check(o_s_axil_bresp, uart_regs_pkg::RESP_OKAY, "bresp");
        @(posedge clk);
        i_s_axil_awvalid <= 1'b0;
        i_s_axil_wvalid  <= 1'b0;
        case (addr)
            uart_regs_pkg::OFF_CR1, uart_regs_pkg::OFF_CR2,
            uart_regs_pkg::OFF_BRR: shadow[addr[4:2]] = data;
            uart_regs_pkg::OFF_TDR: begin
                shadow[addr[4:2]] = data;
                tx_pending = 1'b1;
            end
            uart_regs_pkg::OFF_ICR: sticky = sticky & ~data;
            default: ;
        endcase
    endtask

    task automatic read_reg(input logic [7:0] addr);
        int t;
        @(posedge clk);
        i_s_axil_arvalid <= 1'b1;
        i_s_axil_araddr  <= addr;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) fail_timeout("read address handshake");
        end while (!o_s_axil_arready);
        check(o_s_axil_rvalid, 1, "rvalid with arready");
        check(o_s_axil_rresp, uart_regs_pkg::RESP_OKAY, "rresp");
        rd_addr_seen = addr;
        rd_got = o_s_axil_rdata;
        rd_exp = expected_read(addr);
        -> read_done;
        @(posedge clk);
        i_s_axil_arvalid <= 1'b0;
    endtask

    // compares every read against the model
    initial begin
        forever begin
            @(read_done);
            check(rd_got, rd_exp, $sformatf("read of offset 0x%02h", rd_addr_seen));
        end
    end

    // ====================
    // stimulus
    // ====================
    initial begin
        logic [7:0]  a;
        logic [31:0] word;
        int          i;
        int          t;
        rst = 1'b1;
        i_s_axil_awvalid = 1'b0;
        i_s_axil_awaddr  = '0;
        i_s_axil_wvalid  = 1'b0;
        i_s_axil_wdata   = '0;
        i_s_axil_bready  = 1'b1;
        i_s_axil_arvalid = 1'b0;
        i_s_axil_araddr  = '0;
        i_s_axil_rready  = 1'b1;
        i_tx_ready = 1'b0;
        i_rx_data  = '0;
        i_rx_valid = 1'b0;
        {i_tc, i_idle, i_ore, i_fe, i_pe} = 5'b00000;
        i_busy = 1'b0;
        i_txfe = 1'b0;
        for (i = 0; i < 8; i++) begin
            shadow[i] = '0;
        end
        sticky     = '0;
        tx_pending = 1'b0;
        rx_full    = 1'b0;
        lfsr       = 32'hb16b;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // reset values with only TXE set
        for (a = 8'h00; a < 8'h20; a = a + 8'h04) begin
            read_reg(a);
        end
        read_reg(8'h40);

        // control words in every AW/W order
        for (i = 0; i < 9; i++) begin
            a = 4 * (i % 3);
            write_reg(a, next_bits(32), i / 3);
            @(negedge clk);
            check(o_cr1, shadow[0], "o_cr1");
            check(o_cr2, shadow[1], "o_cr2");
            check(o_brr, shadow[2], "o_brr");
            read_reg(a);
        end
        write_reg(8'h40, next_bits(32), next_bits(2));
        write_reg(uart_regs_pkg::OFF_ICR, next_bits(32), next_bits(2));
        for (a = 8'h00; a < 8'h20; a = a + 8'h04) begin
            read_reg(a);
        end
        read_reg(8'h40);

        // ====================
        // tx stream
        // ====================
        word = next_bits(32);
        write_reg(uart_regs_pkg::OFF_TDR, word, next_bits(2));
        repeat (3) begin
            @(negedge clk);
            check(o_tx_valid, 1, "tx_valid held while tx_ready low");
            check(o_tx_data, word[7:0], "tx_data");
        end
        read_reg(uart_regs_pkg::OFF_ISR);
        read_reg(uart_regs_pkg::OFF_TDR);
        @(posedge clk);
        i_tx_ready <= 1'b1;
        @(posedge clk);
        i_tx_ready <= 1'b0;
        tx_pending = 1'b0;
        @(negedge clk);
        check(o_tx_valid, 0, "tx_valid after one ready cycle");
        read_reg(uart_regs_pkg::OFF_ISR);

        // ====================
        // rx stream
        // ====================
        word = next_bits(8);
        @(posedge clk);
        i_rx_data  <= word[7:0];
        i_rx_valid <= 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) fail_timeout("rx_ready");
        end while (!o_rx_ready);
        @(posedge clk);
        i_rx_valid <= 1'b0;
        rx_full = 1'b1;
        shadow[uart_regs_pkg::OFF_RDR[4:2]] = {24'h0, word[7:0]};
        @(negedge clk);
        check(o_rx_ready, 0, "rx_ready after taking a byte");
        read_reg(uart_regs_pkg::OFF_ISR);
        read_reg(uart_regs_pkg::OFF_RDR);
        rx_full = 1'b0;
        @(negedge clk);
        check(o_rx_ready, 1, "rx_ready after reading RDR");
        read_reg(uart_regs_pkg::OFF_ISR);

        // sticky events one at a time then a masked clear
        for (i = 0; i < 5; i++) begin
            @(posedge clk);
            {i_tc, i_idle, i_ore, i_fe, i_pe} <= 5'b00001 << i;
            @(posedge clk);
            {i_tc, i_idle, i_ore, i_fe, i_pe} <= 5'b00000;
            case (i)
                0: sticky[uart_regs_pkg::ISR_PE] = 1'b1;
                1: sticky[uart_regs_pkg::ISR_FE] = 1'b1;
                2: sticky[uart_regs_pkg::ISR_ORE] = 1'b1;
                3: sticky[uart_regs_pkg::ISR_IDLE] = 1'b1;
                default: sticky[uart_regs_pkg::ISR_TC] = 1'b1;
            endcase
            read_reg(uart_regs_pkg::OFF_ISR);
        end
        repeat (3) @(posedge clk);
        read_reg(uart_regs_pkg::OFF_ISR);
        write_reg(uart_regs_pkg::OFF_ICR, next_bits(32), next_bits(2));
        read_reg(uart_regs_pkg::OFF_ISR);
        @(posedge clk);
        i_busy <= 1'b1;
        i_txfe <= 1'b1;
        read_reg(uart_regs_pkg::OFF_ISR);
        @(posedge clk);
        i_busy <= 1'b0;
        read_reg(uart_regs_pkg::OFF_ISR);

        // ====================
        // B back-pressure
        // ====================
        @(posedge clk);
        i_s_axil_bready <= 1'b0;
        write_reg(uart_regs_pkg::OFF_CR1, next_bits(32), next_bits(2));
        fork
            write_reg(uart_regs_pkg::OFF_CR2, next_bits(32), next_bits(2));
            begin
                repeat (4) begin
                    @(negedge clk);
                    check(o_s_axil_awready || o_s_axil_wready, 0,
                          "write accepted while B pending");
                    check(o_s_axil_bvalid, 1, "bvalid held without bready");
                end
                @(posedge clk);
                i_s_axil_bready <= 1'b1;
            end
        join
        read_reg(uart_regs_pkg::OFF_CR1);
        read_reg(uart_regs_pkg::OFF_CR2);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* source/uart_regs_top.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_regs_top (
    input  wire logic                             clk,
    input  wire logic                             rst,
    // axi-lite slave
    input  wire logic                             i_s_axil_awvalid,
    input  wire logic [uart_regs_pkg::ADDR_W-1:0] i_s_axil_awaddr,
    output logic                                  o_s_axil_awready,
    input  wire logic                             i_s_axil_wvalid,
    input  wire logic [uart_regs_pkg::DATA_W-1:0] i_s_axil_wdata,
    output logic                                  o_s_axil_wready,
    output logic                                  o_s_axil_bvalid,
    output logic      [1:0]                       o_s_axil_bresp,
    input  wire logic                             i_s_axil_bready,
    input  wire logic                             i_s_axil_arvalid,
    input  wire logic [uart_regs_pkg::ADDR_W-1:0] i_s_axil_araddr,
    output logic                                  o_s_axil_arready,
    output logic                                  o_s_axil_rvalid,
    output logic      [uart_regs_pkg::DATA_W-1:0] o_s_axil_rdata,
    output logic      [1:0]                       o_s_axil_rresp,
    input  wire logic                             i_s_axil_rready,
    // uart core side
    output logic      [uart_regs_pkg::DATA_W-1:0] o_cr1,
    output logic      [uart_regs_pkg::DATA_W-1:0] o_cr2,
    output logic      [uart_regs_pkg::DATA_W-1:0] o_brr,
    output logic      [uart_regs_pkg::BYTE_W-1:0] o_tx_data,
    output logic                                  o_tx_valid,
    input  wire logic                             i_tx_ready,
    input  wire logic [uart_regs_pkg::BYTE_W-1:0] i_rx_data,
    input  wire logic                             i_rx_valid,
    output logic                                  o_rx_ready,
    input  wire logic                             i_pe,
    input  wire logic                             i_fe,
    input  wire logic                             i_ore,
    input  wire logic                             i_idle,
    input  wire logic                             i_tc,
    input  wire logic                             i_busy,
    input  wire logic                             i_txfe
);

    wire logic                             wr_en;
    wire logic [uart_regs_pkg::ADDR_W-1:0] wr_addr;
    wire logic [uart_regs_pkg::DATA_W-1:0] wr_data;
    wire logic                             rd_en;
    wire logic [uart_regs_pkg::ADDR_W-1:0] rd_addr;
    wire logic [uart_regs_pkg::DATA_W-1:0] rd_data;
    wire logic [uart_regs_pkg::DATA_W-1:0] tdr;
    wire logic [uart_regs_pkg::DATA_W-1:0] rdr;
    wire logic [uart_regs_pkg::DATA_W-1:0] isr;
    wire logic                             tdr_wr;
    wire logic                             icr_wr;
    wire logic                             rdr_rd;

    axil_write_channel axil_write_channel_i (
        .clk       (clk),
        .rst       (rst),
        .i_awvalid (i_s_axil_awvalid),
        .i_awaddr  (i_s_axil_awaddr),
        .o_awready (o_s_axil_awready),
        .i_wvalid  (i_s_axil_wvalid),
        .i_wdata   (i_s_axil_wdata),
        .o_wready  (o_s_axil_wready),
        .o_bvalid  (o_s_axil_bvalid),
        .o_bresp   (o_s_axil_bresp),
        .i_bready  (i_s_axil_bready),
        .o_wr_en   (wr_en),
        .o_wr_addr (wr_addr),
        .o_wr_data (wr_data)
    );

    axil_read_channel axil_read_channel_i (
        .clk       (clk),
        .rst       (rst),
        .i_arvalid (i_s_axil_arvalid),
        .i_araddr  (i_s_axil_araddr),
        .o_arready (o_s_axil_arready),
        .o_rvalid  (o_s_axil_rvalid),
        .o_rdata   (o_s_axil_rdata),
        .o_rresp   (o_s_axil_rresp),
        .i_rready  (i_s_axil_rready),
        .o_rd_en   (rd_en),
        .o_rd_addr (rd_addr),
        .i_rd_data (rd_data)
    );

    uart_reg_map uart_reg_map_i (
        .clk       (clk),
        .rst       (rst),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data),
        .i_tdr     (tdr),
        .i_rdr     (rdr),
        .i_isr     (isr),
        .o_cr1     (o_cr1),
        .o_cr2     (o_cr2),
        .o_brr     (o_brr),
        .o_tdr_wr  (tdr_wr),
        .o_icr_wr  (icr_wr),
        .o_rdr_rd  (rdr_rd)
    );

    uart_data_path uart_data_path_i (
        .clk        (clk),
        .rst        (rst),
        .i_tdr_wr   (tdr_wr),
        .i_icr_wr   (icr_wr),
        .i_rdr_rd   (rdr_rd),
        .i_wr_data  (wr_data),
        .o_tdr      (tdr),
        .o_rdr      (rdr),
        .o_isr      (isr),
        .o_tx_data  (o_tx_data),
        .o_tx_valid (o_tx_valid),
        .i_tx_ready (i_tx_ready),
        .i_rx_data  (i_rx_data),
        .i_rx_valid (i_rx_valid),
        .o_rx_ready (o_rx_ready),
        .i_pe       (i_pe),
        .i_fe       (i_fe),
        .i_ore      (i_ore),
        .i_idle     (i_idle),
        .i_tc       (i_tc),
        .i_busy     (i_busy),
        .i_txfe     (i_txfe)
    );

endmodule

`default_nettype wire

/* source/uart_data_path.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_data_path (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             i_tdr_wr,
    input  wire logic                             i_icr_wr,
    input  wire logic                             i_rdr_rd,
    input  wire logic [uart_regs_pkg::DATA_W-1:0] i_wr_data,
    output logic      [uart_regs_pkg::DATA_W-1:0] o_tdr,
    output logic      [uart_regs_pkg::DATA_W-1:0] o_rdr,
    output logic      [uart_regs_pkg::DATA_W-1:0] o_isr,
    output logic      [uart_regs_pkg::BYTE_W-1:0] o_tx_data,
    output logic                                  o_tx_valid,
    input  wire logic                             i_tx_ready,
    input  wire logic [uart_regs_pkg::BYTE_W-1:0] i_rx_data,
    input  wire logic                             i_rx_valid,
    output logic                                  o_rx_ready,
    input  wire logic                             i_pe,
    input  wire logic                             i_fe,
    input  wire logic                             i_ore,
    input  wire logic                             i_idle,
    input  wire logic                             i_tc,
    input  wire logic                             i_busy,
    input  wire logic                             i_txfe
);

    logic [uart_regs_pkg::DATA_W-1:0]   tdr_q;
    logic [uart_regs_pkg::BYTE_W-1:0]   rdr_q;
    logic                               tx_valid_q;
    logic                               rx_ready_q;
    logic [uart_regs_pkg::ISR_TXFE:0]   isr_q;
    logic [uart_regs_pkg::DATA_W-1:0]   clr_mask;

    // set beats clear
    function automatic logic sticky_next(input logic cur, input logic set, input logic clr);
        sticky_next = set || (cur && !clr);
    endfunction

    // ====================
    // tx side
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            tdr_q      <= '0;
            tx_valid_q <= 1'b0;
        end else if (i_tdr_wr) begin
            tdr_q      <= i_wr_data;
            tx_valid_q <= 1'b1;
        end else if (i_tx_ready) begin
            tx_valid_q <= 1'b0;
        end
    end

    // ====================
    // rx side
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            rdr_q      <= '0;
            rx_ready_q <= 1'b1;
        end else if (i_rx_valid && rx_ready_q) begin
            rdr_q      <= i_rx_data;
            rx_ready_q <= 1'b0;
        end else if (i_rdr_rd) begin
            rx_ready_q <= 1'b1;
        end
    end

    // ====================
    // status flags
    // ====================
    assign clr_mask = i_icr_wr ? i_wr_data : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            isr_q <= '0;
        end else begin
            isr_q[uart_regs_pkg::ISR_PE] <= sticky_next(isr_q[uart_regs_pkg::ISR_PE], i_pe,
                clr_mask[uart_regs_pkg::ISR_PE]);
            isr_q[uart_regs_pkg::ISR_FE] <= sticky_next(isr_q[uart_regs_pkg::ISR_FE], i_fe,
                clr_mask[uart_regs_pkg::ISR_FE]);
            isr_q[uart_regs_pkg::ISR_ORE] <= sticky_next(isr_q[uart_regs_pkg::ISR_ORE], i_ore,
                clr_mask[uart_regs_pkg::ISR_ORE]);
            isr_q[uart_regs_pkg::ISR_IDLE] <= sticky_next(isr_q[uart_regs_pkg::ISR_IDLE], i_idle,
                clr_mask[uart_regs_pkg::ISR_IDLE]);
            isr_q[uart_regs_pkg::ISR_TC] <= sticky_next(isr_q[uart_regs_pkg::ISR_TC], i_tc,
                clr_mask[uart_regs_pkg::ISR_TC]);
            // rxne and txe mirror the stream registers
            isr_q[uart_regs_pkg::ISR_RXNE] <= !rx_ready_q;
            isr_q[uart_regs_pkg::ISR_TXE]  <= !tx_valid_q;
            isr_q[uart_regs_pkg::ISR_BUSY] <= i_busy;
            isr_q[uart_regs_pkg::ISR_TXFE] <= i_txfe;
        end
    end

    assign o_tdr      = tdr_q;
    // received byte zero-extended
    assign o_rdr      = {{(uart_regs_pkg::DATA_W-uart_regs_pkg::BYTE_W){1'b0}}, rdr_q};
    assign o_isr      = {{(uart_regs_pkg::DATA_W-uart_regs_pkg::ISR_TXFE-1){1'b0}}, isr_q};
    assign o_tx_data  = tdr_q[uart_regs_pkg::BYTE_W-1:0];
    assign o_tx_valid = tx_valid_q;
    assign o_rx_ready = rx_ready_q;

endmodule

`default_nettype wire

/* source/uart_reg_map.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_reg_map (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             i_wr_en,
    input  wire logic [uart_regs_pkg::ADDR_W-1:0] i_wr_addr,
    input  wire logic [uart_regs_pkg::DATA_W-1:0] i_wr_data,
    input  wire logic                             i_rd_en,
    input  wire logic [uart_regs_pkg::ADDR_W-1:0] i_rd_addr,
    output logic      [uart_regs_pkg::DATA_W-1:0] o_rd_data,
    input  wire logic [uart_regs_pkg::DATA_W-1:0] i_tdr,
    input  wire logic [uart_regs_pkg::DATA_W-1:0] i_rdr,
    input  wire logic [uart_regs_pkg::DATA_W-1:0] i_isr,
    output logic      [uart_regs_pkg::DATA_W-1:0] o_cr1,
    output logic      [uart_regs_pkg::DATA_W-1:0] o_cr2,
    output logic      [uart_regs_pkg::DATA_W-1:0] o_brr,
    output logic                                  o_tdr_wr,
    output logic                                  o_icr_wr,
    output logic                                  o_rdr_rd
);

    logic [uart_regs_pkg::DATA_W-1:0] cr1_q;
    logic [uart_regs_pkg::DATA_W-1:0] cr2_q;
    logic [uart_regs_pkg::DATA_W-1:0] brr_q;

    // ====================
    // control words
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            cr1_q <= '0;
            cr2_q <= '0;
            brr_q <= '0;
        end else if (i_wr_en) begin
            case (i_wr_addr)
                uart_regs_pkg::OFF_CR1: cr1_q <= i_wr_data;
                uart_regs_pkg::OFF_CR2: cr2_q <= i_wr_data;
                uart_regs_pkg::OFF_BRR: brr_q <= i_wr_data;
                // unmapped offsets are dropped
                default: ;
            endcase
        end
    end

    assign o_cr1 = cr1_q;
    assign o_cr2 = cr2_q;
    assign o_brr = brr_q;

    // ====================
    // data path strobes
    // ====================
    assign o_tdr_wr = i_wr_en && (i_wr_addr == uart_regs_pkg::OFF_TDR);
    assign o_icr_wr = i_wr_en && (i_wr_addr == uart_regs_pkg::OFF_ICR);
    // reading RDR frees the rx slot
    assign o_rdr_rd = i_rd_en && (i_rd_addr == uart_regs_pkg::OFF_RDR);

    // ====================
    // read mux
    // ====================
    always_comb begin
        case (i_rd_addr)
            uart_regs_pkg::OFF_CR1: o_rd_data = cr1_q;
            uart_regs_pkg::OFF_CR2: o_rd_data = cr2_q;
            uart_regs_pkg::OFF_BRR: o_rd_data = brr_q;
            uart_regs_pkg::OFF_ISR: o_rd_data = i_isr;
            uart_regs_pkg::OFF_RDR: o_rd_data = i_rdr;
            uart_regs_pkg::OFF_TDR: o_rd_data = i_tdr;
            // icr and holes
            default:                o_rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/axil_read_channel.sv */
`timescale 1ns/10ps
`default_nettype none

module axil_read_channel (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             i_arvalid,
    input  wire logic [uart_regs_pkg::ADDR_W-1:0] i_araddr,
    output logic                                  o_arready,
    output logic                                  o_rvalid,
    output logic      [uart_regs_pkg::DATA_W-1:0] o_rdata,
    output logic      [1:0]                       o_rresp,
    input  wire logic                             i_rready,
    output logic                                  o_rd_en,
    output logic      [uart_regs_pkg::ADDR_W-1:0] o_rd_addr,
    input  wire logic [uart_regs_pkg::DATA_W-1:0] i_rd_data
);

    logic                             arready_q;
    logic                             rvalid_q;
    logic [uart_regs_pkg::DATA_W-1:0] rdata_q;

    // one read in flight, a new one only once R drains
    assign o_rd_en   = i_arvalid && !arready_q && (!rvalid_q || i_rready);
    assign o_rd_addr = i_araddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            arready_q <= o_rd_en;
            rvalid_q  <= o_rd_en || (rvalid_q && !i_rready);
        end
    end

    // sample the map output on the accepting edge
    always_ff @(posedge clk) begin
        if (o_rd_en) begin
            rdata_q <= i_rd_data;
        end
    end

    assign o_arready = arready_q;
    assign o_rvalid  = rvalid_q;
    assign o_rdata   = rdata_q;
    assign o_rresp   = uart_regs_pkg::RESP_OKAY;

endmodule

`default_nettype wire

/* source/axil_write_channel.sv */
`timescale 1ns/10ps
`default_nettype none

module axil_write_channel (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             i_awvalid,
    input  wire logic [uart_regs_pkg::ADDR_W-1:0] i_awaddr,
    output logic                                  o_awready,
    input  wire logic                             i_wvalid,
    input  wire logic [uart_regs_pkg::DATA_W-1:0] i_wdata,
    output logic                                  o_wready,
    output logic                                  o_bvalid,
    output logic      [1:0]                       o_bresp,
    input  wire logic                             i_bready,
    output logic                                  o_wr_en,
    output logic      [uart_regs_pkg::ADDR_W-1:0] o_wr_addr,
    output logic      [uart_regs_pkg::DATA_W-1:0] o_wr_data
);

    logic                             awready_q;
    logic                             wready_q;
    logic                             bvalid_q;
    logic                             aw_held_q;
    logic                             w_held_q;
    logic [uart_regs_pkg::ADDR_W-1:0] awaddr_q;
    logic [uart_regs_pkg::DATA_W-1:0] wdata_q;
    logic                             b_free;
    logic                             aw_take;
    logic                             w_take;

    // ====================
    // accept decisions
    // ====================
    // a pending B response blocks both halves until bready
    assign b_free  = !bvalid_q || i_bready;
    assign aw_take = i_awvalid && !aw_held_q && !awready_q && b_free;
    assign w_take  = i_wvalid && !w_held_q && !wready_q && b_free;

    // second half in, or both together
    assign o_wr_en = (aw_take || aw_held_q) && (w_take || w_held_q) && (aw_take || w_take);

    // held half wins over the bus
    assign o_wr_addr = aw_held_q ? awaddr_q : i_awaddr;
    assign o_wr_data = w_held_q ? wdata_q : i_wdata;

    // ====================
    // handshake state
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            bvalid_q  <= 1'b0;
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
        end else begin
            awready_q <= aw_take;
            wready_q  <= w_take;
            if (o_wr_en) begin
                bvalid_q  <= 1'b1;
                aw_held_q <= 1'b0;
                w_held_q  <= 1'b0;
            end else begin
                bvalid_q <= bvalid_q && !i_bready;
                if (aw_take) begin
                    aw_held_q <= 1'b1;
                end
                if (w_take) begin
                    w_held_q <= 1'b1;
                end
            end
        end
    end

    // first-arriving half is parked here
    always_ff @(posedge clk) begin
        if (aw_take) begin
            awaddr_q <= i_awaddr;
        end
        if (w_take) begin
            wdata_q <= i_wdata;
        end
    end

    assign o_awready = awready_q;
    assign o_wready  = wready_q;
    assign o_bvalid  = bvalid_q;
    assign o_bresp   = uart_regs_pkg::RESP_OKAY;

endmodule

`default_nettype wire

/* source/uart_regs_pkg.sv */
`default_nettype none

package uart_regs_pkg;

    // ====================
    // widths
    // ====================
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int BYTE_W = 8;

    // ====================
    // register offsets
    // ====================
    localparam logic [ADDR_W-1:0] OFF_CR1 = 8'h00;
    localparam logic [ADDR_W-1:0] OFF_CR2 = 8'h04;
    localparam logic [ADDR_W-1:0] OFF_BRR = 8'h08;
    localparam logic [ADDR_W-1:0] OFF_ISR = 8'h0C;
    // write-one-to-clear and reads as zero
    localparam logic [ADDR_W-1:0] OFF_ICR = 8'h10;
    localparam logic [ADDR_W-1:0] OFF_RDR = 8'h14;
    localparam logic [ADDR_W-1:0] OFF_TDR = 8'h18;

    // ====================
    // isr / icr bit positions
    // ====================
    // sticky event flags
    localparam int ISR_PE   = 0;
    localparam int ISR_FE   = 1;
    localparam int ISR_ORE  = 2;
    localparam int ISR_IDLE = 3;
    // live flags except tc which is sticky
    localparam int ISR_RXNE = 4;
    localparam int ISR_TC   = 5;
    localparam int ISR_TXE  = 6;
    localparam int ISR_BUSY = 7;
    localparam int ISR_TXFE = 8;

    // axi-lite response code
    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire
